// ==== verilog/decode_pkg.sv ====
/*
 * decode stage package
 * field widths, control codes, RV32I opcodes and bubble constants
 */
package decode_pkg;

    localparam int REG_COUNT = 32;

    typedef logic [31:0] word_t;     // data, pc or instruction
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  alu_fun_t;
    typedef logic [3:0]  op1_sel_t;
    typedef logic [3:0]  op2_sel_t;
    typedef logic [3:0]  mem_fun_t;
    typedef logic [3:0]  wb_sel_t;

    // execute function codes
    localparam alu_fun_t ALU_ADD  = 5'd1;
    localparam alu_fun_t ALU_SUB  = 5'd2;
    localparam alu_fun_t ALU_AND  = 5'd3;
    localparam alu_fun_t ALU_OR   = 5'd4;
    localparam alu_fun_t ALU_XOR  = 5'd5;
    localparam alu_fun_t ALU_SLL  = 5'd6;
    localparam alu_fun_t ALU_SRL  = 5'd7;
    localparam alu_fun_t ALU_SRA  = 5'd8;
    localparam alu_fun_t ALU_SLT  = 5'd9;
    localparam alu_fun_t ALU_SLTU = 5'd10;
    localparam alu_fun_t BR_BEQ   = 5'd11;  // branch compares in the same field
    localparam alu_fun_t BR_BNE   = 5'd12;
    localparam alu_fun_t BR_BLT   = 5'd13;
    localparam alu_fun_t BR_BGE   = 5'd14;
    localparam alu_fun_t BR_BLTU  = 5'd15;
    localparam alu_fun_t BR_BGEU  = 5'd16;
    localparam alu_fun_t ALU_JALR = 5'd17;

    localparam op1_sel_t OP1_X   = 4'd0;
    localparam op1_sel_t OP1_RS1 = 4'd1;
    localparam op1_sel_t OP1_PC  = 4'd2;

    localparam op2_sel_t OP2_X   = 4'd0;
    localparam op2_sel_t OP2_RS2 = 4'd1;
    localparam op2_sel_t OP2_IMI = 4'd2;
    localparam op2_sel_t OP2_IMS = 4'd3;
    localparam op2_sel_t OP2_IMJ = 4'd4;
    localparam op2_sel_t OP2_IMU = 4'd5;

    localparam mem_fun_t MEM_X   = 4'd0;
    localparam mem_fun_t MEM_LB  = 4'd1;
    localparam mem_fun_t MEM_LBU = 4'd2;
    localparam mem_fun_t MEM_LH  = 4'd3;
    localparam mem_fun_t MEM_LHU = 4'd4;
    localparam mem_fun_t MEM_LW  = 4'd5;
    localparam mem_fun_t MEM_SB  = 4'd6;
    localparam mem_fun_t MEM_SH  = 4'd7;
    localparam mem_fun_t MEM_SW  = 4'd8;

    localparam wb_sel_t WB_X      = 4'd0;
    localparam wb_sel_t WB_ALU    = 4'd1;
    localparam wb_sel_t WB_PC     = 4'd2;
    localparam wb_sel_t WB_MEMB   = 4'd3;
    localparam wb_sel_t WB_MEMBU  = 4'd4;
    localparam wb_sel_t WB_MEMH   = 4'd5;
    localparam wb_sel_t WB_MEMHU  = 4'd6;
    localparam wb_sel_t WB_MEMW   = 4'd7;

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // alu funct3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // srl and sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    // load/store size
    localparam logic [2:0] F3_B    = 3'b000;
    localparam logic [2:0] F3_H    = 3'b001;
    localparam logic [2:0] F3_W    = 3'b010;
    localparam logic [2:0] F3_BU   = 3'b100;
    localparam logic [2:0] F3_HU   = 3'b101;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra, srai

    localparam word_t INST_NOP = 32'h0000_0013;  // addi x0, x0, 0
    localparam word_t PC_NOP   = 32'h0000_0000;

endpackage

// ==== verilog/inst_hold.sv ====
/*
 * instruction hold and flush selector
 * presents the flushed, replayed or incoming instruction to decode
 */
`timescale 1ns/100ps

module inst_hold import decode_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  in_valid,
    input  word_t in_pc,
    input  word_t in_inst,
    input  logic  stall,
    input  logic  branch_flush,
    output word_t pc,
    output word_t inst
);

    logic  held;  // replay pending
    word_t held_pc;
    word_t held_inst;

    always_comb begin
        if (branch_flush) begin
            pc   = PC_NOP;
            inst = INST_NOP;
        end else if (held) begin
            pc   = held_pc;
            inst = held_inst;
        end else begin
            pc   = in_valid ? in_pc : PC_NOP;
            inst = in_valid ? in_inst : INST_NOP;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            held <= 1'b0;
        else
            held <= stall && !branch_flush;  // flush drops the replay

        if (stall) begin
            held_pc   <= pc;
            held_inst <= inst;
        end
    end

endmodule

// ==== verilog/control_decoder.sv ====
/*
 * RV32I control decoder
 * maps opcode, funct3 and funct7 onto the execute control fields
 */
`timescale 1ns/100ps

module control_decoder import decode_pkg::*; (
    input  word_t    inst,
    output alu_fun_t alu_fun,
    output op1_sel_t op1_sel,
    output op2_sel_t op2_sel,
    output mem_fun_t mem_fun,
    output logic     rf_wen,
    output wb_sel_t  wb_sel,
    output logic     jmp_flg
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [21:0] ctrl;  // alu, op1, op2, mem, rf_wen, wb

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign {alu_fun, op1_sel, op2_sel, mem_fun, rf_wen, wb_sel} = ctrl;
    assign jmp_flg = (opcode == OPC_JAL) || (opcode == OPC_JALR && funct3 == F3_JALR);

    always_comb begin
        ctrl = {ALU_ADD, OP1_X, OP2_X, MEM_X, 1'b0, WB_X};  // unmatched encodings
        case (opcode)
            OPC_LOAD:
                case (funct3)
                    F3_B:  ctrl = {ALU_ADD, OP1_RS1, OP2_IMI, MEM_LB, 1'b1, WB_MEMB};
                    F3_BU: ctrl = {ALU_ADD, OP1_RS1, OP2_IMI, MEM_LBU, 1'b1, WB_MEMBU};
                    F3_H:  ctrl = {ALU_ADD, OP1_RS1, OP2_IMI, MEM_LH, 1'b1, WB_MEMH};
                    F3_HU: ctrl = {ALU_ADD, OP1_RS1, OP2_IMI, MEM_LHU, 1'b1, WB_MEMHU};
                    F3_W:  ctrl = {ALU_ADD, OP1_RS1, OP2_IMI, MEM_LW, 1'b1, WB_MEMW};
                endcase
            OPC_STORE:
                case (funct3)
                    F3_B: ctrl = {ALU_ADD, OP1_RS1, OP2_IMS, MEM_SB, 1'b0, WB_X};
                    F3_H: ctrl = {ALU_ADD, OP1_RS1, OP2_IMS, MEM_SH, 1'b0, WB_X};
                    F3_W: ctrl = {ALU_ADD, OP1_RS1, OP2_IMS, MEM_SW, 1'b0, WB_X};
                endcase
            OPC_OP:
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD}:  ctrl = {ALU_ADD, OP1_RS1, OP2_RS2, MEM_X, 1'b1, WB_ALU};
                    {F7_ALT, F3_ADD}:   ctrl = {ALU_SUB, OP1_RS1, OP2_RS2, MEM_X, 1'b1, WB_ALU};
                    {F7_BASE, F3_AND}:  ctrl = {ALU_AND, OP1_RS1, OP2_RS2, MEM_X, 1'b1, WB_ALU};
                    {F7_BASE, F3_OR}:   ctrl = {ALU_OR, OP1_RS1, OP2_RS2, MEM_X, 1'b1, WB_ALU};
                    {F7_BASE, F3_XOR}:  ctrl = {ALU_XOR, OP1_RS1, OP2_RS2, MEM_X, 1'b1, WB_ALU};
                    {F7_BASE, F3_SLL}:  ctrl = {ALU_SLL, OP1_RS1, OP2_RS2, MEM_X, 1'b1, WB_ALU};
                    {F7_BASE, F3_SR}:   ctrl = {ALU_SRL, OP1_RS1, OP2_RS2, MEM_X, 1'b1, WB_ALU};
                    {F7_ALT, F3_SR}:    ctrl = {ALU_SRA, OP1_RS1, OP2_RS2, MEM_X, 1'b1, WB_ALU};
                    {F7_BASE, F3_SLT}:  ctrl = {ALU_SLT, OP1_RS1, OP2_RS2, MEM_X, 1'b1, WB_ALU};
                    {F7_BASE, F3_SLTU}: ctrl = {ALU_SLTU, OP1_RS1, OP2_RS2, MEM_X, 1'b1, WB_ALU};
                endcase
            OPC_OP_IMM:
                case (funct3)
                    F3_ADD:  ctrl = {ALU_ADD, OP1_RS1, OP2_IMI, MEM_X, 1'b1, WB_ALU};
                    F3_AND:  ctrl = {ALU_AND, OP1_RS1, OP2_IMI, MEM_X, 1'b1, WB_ALU};
                    F3_OR:   ctrl = {ALU_OR, OP1_RS1, OP2_IMI, MEM_X, 1'b1, WB_ALU};
                    F3_XOR:  ctrl = {ALU_XOR, OP1_RS1, OP2_IMI, MEM_X, 1'b1, WB_ALU};
                    F3_SLT:  ctrl = {ALU_SLT, OP1_RS1, OP2_IMI, MEM_X, 1'b1, WB_ALU};
                    F3_SLTU: ctrl = {ALU_SLTU, OP1_RS1, OP2_IMI, MEM_X, 1'b1, WB_ALU};
                    F3_SLL:
                        if (funct7 == F7_BASE)
                            ctrl = {ALU_SLL, OP1_RS1, OP2_IMI, MEM_X, 1'b1, WB_ALU};
                    F3_SR:
                        if (funct7 == F7_BASE)
                            ctrl = {ALU_SRL, OP1_RS1, OP2_IMI, MEM_X, 1'b1, WB_ALU};
                        else if (funct7 == F7_ALT)
                            ctrl = {ALU_SRA, OP1_RS1, OP2_IMI, MEM_X, 1'b1, WB_ALU};
                endcase
            OPC_BRANCH:
                case (funct3)
                    F3_BEQ:  ctrl = {BR_BEQ, OP1_RS1, OP2_RS2, MEM_X, 1'b0, WB_X};
                    F3_BNE:  ctrl = {BR_BNE, OP1_RS1, OP2_RS2, MEM_X, 1'b0, WB_X};
                    F3_BLT:  ctrl = {BR_BLT, OP1_RS1, OP2_RS2, MEM_X, 1'b0, WB_X};
                    F3_BGE:  ctrl = {BR_BGE, OP1_RS1, OP2_RS2, MEM_X, 1'b0, WB_X};
                    F3_BLTU: ctrl = {BR_BLTU, OP1_RS1, OP2_RS2, MEM_X, 1'b0, WB_X};
                    F3_BGEU: ctrl = {BR_BGEU, OP1_RS1, OP2_RS2, MEM_X, 1'b0, WB_X};
                endcase
            OPC_JAL:   ctrl = {ALU_ADD, OP1_PC, OP2_IMJ, MEM_X, 1'b1, WB_PC};
            OPC_JALR:
                if (funct3 == F3_JALR)
                    ctrl = {ALU_JALR, OP1_RS1, OP2_IMI, MEM_X, 1'b1, WB_PC};
            OPC_LUI:   ctrl = {ALU_ADD, OP1_X, OP2_IMU, MEM_X, 1'b1, WB_ALU};
            OPC_AUIPC: ctrl = {ALU_ADD, OP1_PC, OP2_IMU, MEM_X, 1'b1, WB_ALU};
            default:   ctrl = {ALU_ADD, OP1_X, OP2_X, MEM_X, 1'b0, WB_X};
        endcase
    end

endmodule

// ==== verilog/operand_select.sv ====
/*
 * immediate generation and operand selection
 * builds the five immediate forms and the op1/op2 words for execute
 */
`timescale 1ns/100ps

module operand_select import decode_pkg::*; (
    input  word_t     pc,
    input  word_t     inst,
    input  word_t     rs1_value,
    input  word_t     rs2_value,
    input  op1_sel_t  op1_sel,
    input  op2_sel_t  op2_sel,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output word_t     imm_i,
    output word_t     imm_s,
    output word_t     imm_b,
    output word_t     imm_j,
    output word_t     imm_u,
    output word_t     op1_data,
    output word_t     op2_data,
    output word_t     rs2_data
);

    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    // sign extended from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    assign rs2_data = rs2_value;  // store data and branch compare

    always_comb begin
        case (op1_sel)
            OP1_RS1: op1_data = rs1_value;
            OP1_PC:  op1_data = pc;
            default: op1_data = '0;  // OP1_X, lui
        endcase
    end

    always_comb begin
        case (op2_sel)
            OP2_RS2: op2_data = rs2_value;
            OP2_IMI: op2_data = imm_i;
            OP2_IMS: op2_data = imm_s;
            OP2_IMJ: op2_data = imm_j;
            OP2_IMU: op2_data = imm_u;
            default: op2_data = '0;
        endcase
    end

endmodule

// ==== verilog/reg_file.sv ====
/*
 * integer register file
 * 32 entries with x0 at zero, two async read ports, one write port
 */
`timescale 1ns/100ps

module reg_file import decode_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      rf_we,
    input  reg_addr_t rf_waddr,
    input  word_t     rf_wdata,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_value,
    output word_t     rs2_value
);

    word_t regs [1:REG_COUNT-1];  // no storage for x0

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < REG_COUNT; i++)
                regs[i] <= '0;
        end else if (rf_we && rf_waddr != '0) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // no bypass, a same-cycle write shows up next cycle
    assign rs1_value = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_value = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== verilog/hazard_detect.sv ====
/*
 * data hazard detection
 * stalls while a later stage still owes a write to rs1 or rs2
 */
`timescale 1ns/100ps

module hazard_detect import decode_pkg::*; (
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  logic      exe_rf_wen,
    input  reg_addr_t exe_wb_addr,
    input  logic      mem_rf_wen,
    input  reg_addr_t mem_wb_addr,
    input  logic      wb_rf_wen,
    input  reg_addr_t wb_wb_addr,
    input  logic      branch_flush,
    output logic      hazard_stall
);

    logic rs1_pending;
    logic rs2_pending;

    // checked whether or not the operand is used
    assign rs1_pending = (rs1_addr != '0) && ((exe_rf_wen && exe_wb_addr == rs1_addr) ||
                                              (mem_rf_wen && mem_wb_addr == rs1_addr) ||
                                              (wb_rf_wen && wb_wb_addr == rs1_addr));
    assign rs2_pending = (rs2_addr != '0) && ((exe_rf_wen && exe_wb_addr == rs2_addr) ||
                                              (mem_rf_wen && mem_wb_addr == rs2_addr) ||
                                              (wb_rf_wen && wb_wb_addr == rs2_addr));

    assign hazard_stall = !branch_flush && (rs1_pending || rs2_pending);  // flushed inst is dead

endmodule

// ==== verilog/decode_output_reg.sv ====
/*
 * decode to execute pipeline register
 * loads a bubble on stall or reset, otherwise the decoded fields
 */
`timescale 1ns/100ps

module decode_output_reg import decode_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      mem_stall,
    input  logic      hazard_stall,
    input  word_t     pc,
    input  word_t     inst,
    input  word_t     imm_i,
    input  word_t     imm_s,
    input  word_t     imm_b,
    input  word_t     imm_j,
    input  word_t     imm_u,
    input  word_t     op1_data,
    input  word_t     op2_data,
    input  word_t     rs2_data,
    input  reg_addr_t wb_addr,
    input  alu_fun_t  alu_fun,
    input  mem_fun_t  mem_fun,
    input  logic      rf_wen,
    input  wb_sel_t   wb_sel,
    input  logic      jmp_flg,
    output logic      stall,
    output word_t     out_pc,
    output word_t     out_inst,
    output word_t     out_imm_i,
    output word_t     out_imm_s,
    output word_t     out_imm_b,
    output word_t     out_imm_j,
    output word_t     out_imm_u,
    output word_t     out_op1_data,
    output word_t     out_op2_data,
    output word_t     out_rs2_data,
    output reg_addr_t out_wb_addr,
    output alu_fun_t  out_alu_fun,
    output mem_fun_t  out_mem_fun,
    output logic      out_rf_wen,
    output wb_sel_t   out_wb_sel,
    output logic      out_jmp_flg
);

    assign stall = mem_stall || hazard_stall;

    always_ff @(posedge clk) begin
        if (reset || stall) begin
            // bubble
            out_pc   <= PC_NOP;
            out_inst <= INST_NOP;
            {out_imm_i, out_imm_s, out_imm_b, out_imm_j, out_imm_u} <= '0;
            {out_op1_data, out_op2_data, out_rs2_data} <= '0;
            out_wb_addr <= '0;
            out_alu_fun <= ALU_ADD;
            out_mem_fun <= MEM_X;
            out_rf_wen  <= 1'b0;
            out_wb_sel  <= WB_X;
            out_jmp_flg <= 1'b0;
        end else begin
            out_pc       <= pc;
            out_inst     <= inst;
            out_imm_i    <= imm_i;
            out_imm_s    <= imm_s;
            out_imm_b    <= imm_b;
            out_imm_j    <= imm_j;
            out_imm_u    <= imm_u;
            out_op1_data <= op1_data;
            out_op2_data <= op2_data;
            out_rs2_data <= rs2_data;
            out_wb_addr  <= wb_addr;
            out_alu_fun  <= alu_fun;
            out_mem_fun  <= mem_fun;
            out_rf_wen   <= rf_wen;
            out_wb_sel   <= wb_sel;
            out_jmp_flg  <= jmp_flg;
        end
    end

endmodule

// ==== verilog/decode_stage.sv ====
/*
 * RV32I decode stage
 * hold/flush select, decode, operand fetch, hazard check, output register
 */
`timescale 1ns/100ps

module decode_stage import decode_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  word_t     in_pc,
    input  word_t     in_inst,
    input  logic      mem_stall,
    input  logic      branch_flush,
    input  logic      exe_rf_wen,
    input  reg_addr_t exe_wb_addr,
    input  logic      mem_rf_wen,
    input  reg_addr_t mem_wb_addr,
    input  logic      wb_rf_wen,
    input  reg_addr_t wb_wb_addr,
    input  logic      rf_we,
    input  reg_addr_t rf_waddr,
    input  word_t     rf_wdata,
    output logic      hazard_stall,
    output word_t     out_pc,
    output word_t     out_inst,
    output word_t     out_imm_i,
    output word_t     out_imm_s,
    output word_t     out_imm_b,
    output word_t     out_imm_j,
    output word_t     out_imm_u,
    output word_t     out_op1_data,
    output word_t     out_op2_data,
    output word_t     out_rs2_data,
    output reg_addr_t out_wb_addr,
    output alu_fun_t  out_alu_fun,
    output mem_fun_t  out_mem_fun,
    output logic      out_rf_wen,
    output wb_sel_t   out_wb_sel,
    output logic      out_jmp_flg
);

    logic      stall;
    word_t     pc;
    word_t     inst;
    alu_fun_t  alu_fun;
    op1_sel_t  op1_sel;
    op2_sel_t  op2_sel;
    mem_fun_t  mem_fun;
    logic      rf_wen;
    wb_sel_t   wb_sel;
    logic      jmp_flg;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_value;
    word_t     rs2_value;
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_b;
    word_t     imm_j;
    word_t     imm_u;
    word_t     op1_data;
    word_t     op2_data;
    word_t     rs2_data;

    inst_hold         i_inst_hold (.*);
    control_decoder   i_control_decoder (.*);
    operand_select    i_operand_select (.*);
    reg_file          i_reg_file (.*);
    hazard_detect     i_hazard_detect (.*);
    decode_output_reg i_decode_output_reg (.*, .wb_addr(inst[11:7]));

endmodule

// ==== verification/decode_stage_assert.sv ====
/*
 * decode stage assertions
 * stall and bubble behaviour, flush priority and reset of the output register
 */
`timescale 1ns/100ps

module decode_stage_assert import decode_pkg::*; (
    input logic     clk,
    input logic     reset,
    input logic     stall,
    input logic     branch_flush,
    input logic     hazard_stall,
    input logic     out_rf_wen,
    input mem_fun_t out_mem_fun,
    input wb_sel_t  out_wb_sel,
    input logic     out_jmp_flg,
    input word_t    out_pc
);

    int fail_count = 0;  // read by the testbench

    stall_gives_bubble: assert property (@(posedge clk) disable iff (reset)
        stall |=> (!out_rf_wen && out_mem_fun == MEM_X && out_wb_sel == WB_X &&
                   !out_jmp_flg && out_pc == PC_NOP))
    else begin
        fail_count++;
        $error("stall cycle was not followed by a bubble");
    end

    flush_masks_hazard: assert property (@(posedge clk) branch_flush |-> !hazard_stall)
    else begin
        fail_count++;
        $error("hazard_stall high during branch_flush");
    end

    reset_clears_wen: assert property (@(posedge clk) reset |=> !out_rf_wen)
    else begin
        fail_count++;
        $error("rf_wen still set after a reset cycle");
    end

endmodule

bind decode_stage decode_stage_assert i_decode_stage_assert (.*);

// ==== verification/decode_stage_tb.sv ====
/*
 * decode stage testbench
 * random RV32I stream with stalls, flushes and register writes,
 * checked cycle by cycle against a reference model
 */
`timescale 1ns/100ps

module decode_stage_tb import decode_pkg::*; ();

    localparam int NUM_CYCLES = 3000;
    localparam int TIMEOUT_NS = (NUM_CYCLES + 16 + 100) * 10;

    logic      clk;
    logic      reset;
    logic      in_valid;
    word_t     in_pc;
    word_t     in_inst;
    logic      mem_stall;
    logic      branch_flush;
    logic      exe_rf_wen;
    reg_addr_t exe_wb_addr;
    logic      mem_rf_wen;
    reg_addr_t mem_wb_addr;
    logic      wb_rf_wen;
    reg_addr_t wb_wb_addr;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;
    logic      hazard_stall;
    word_t     out_pc, out_inst, out_imm_i, out_imm_s, out_imm_b, out_imm_j, out_imm_u;
    word_t     out_op1_data, out_op2_data, out_rs2_data;
    reg_addr_t out_wb_addr;
    alu_fun_t  out_alu_fun;
    mem_fun_t  out_mem_fun;
    logic      out_rf_wen;
    wb_sel_t   out_wb_sel;
    logic      out_jmp_flg;

    // model state
    word_t     m_regs [0:REG_COUNT-1];
    logic      m_held;
    word_t     m_held_pc;
    word_t     m_held_inst;
    word_t     exp_pc, exp_inst, exp_imm_i, exp_imm_s, exp_imm_b, exp_imm_j, exp_imm_u;
    word_t     exp_op1, exp_op2, exp_rs2;
    reg_addr_t exp_wb_addr;
    alu_fun_t  exp_alu;
    mem_fun_t  exp_mem;
    logic      exp_rf_wen;
    wb_sel_t   exp_wb_sel;
    logic      exp_jmp;

    integer seed;
    int     errors = 0;
    int     checks = 0;

    decode_stage i_decode_stage (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the test sequence finished");
        $display("TEST FAILED");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic write_pending(input reg_addr_t a);
        logic hit;
        hit = (exe_rf_wen && exe_wb_addr == a) || (mem_rf_wen && mem_wb_addr == a);
        hit = hit || (wb_rf_wen && wb_wb_addr == a);
        return (a != 5'd0) && hit;
    endfunction

    task automatic load_bubble();
        exp_pc = PC_NOP;
        exp_inst = INST_NOP;
        {exp_imm_i, exp_imm_s, exp_imm_b, exp_imm_j, exp_imm_u} = '0;
        {exp_op1, exp_op2, exp_rs2} = '0;
        exp_wb_addr = '0;
        exp_alu = ALU_ADD;
        exp_mem = MEM_X;
        exp_rf_wen = 1'b0;
        exp_wb_sel = WB_X;
        exp_jmp = 1'b0;
    endtask

    // reference decode for the encodings the generator produces
    task automatic decode_model(input word_t ins, output alu_fun_t alu, output op1_sel_t s1,
                                output op2_sel_t s2, output mem_fun_t mem, output logic wen,
                                output wb_sel_t wb, output logic jmp);
        logic [2:0] f3;
        f3 = ins[14:12];
        alu = ALU_ADD;
        s1 = OP1_RS1;
        s2 = OP2_IMI;
        mem = MEM_X;
        wen = 1'b1;
        wb = WB_ALU;
        jmp = 1'b0;
        case (ins[6:0])
            OPC_OP, OPC_OP_IMM: begin
                if (ins[6:0] == OPC_OP)
                    s2 = OP2_RS2;
                case (f3)
                    F3_ADD:  alu = (ins[6:0] == OPC_OP && ins[30]) ? ALU_SUB : ALU_ADD;
                    F3_SLL:  alu = ALU_SLL;
                    F3_SLT:  alu = ALU_SLT;
                    F3_SLTU: alu = ALU_SLTU;
                    F3_XOR:  alu = ALU_XOR;
                    F3_SR:   alu = ins[30] ? ALU_SRA : ALU_SRL;
                    F3_OR:   alu = ALU_OR;
                    default: alu = ALU_AND;
                endcase
            end
            OPC_LOAD:
                case (f3)
                    F3_B:    {mem, wb} = {MEM_LB, WB_MEMB};
                    F3_H:    {mem, wb} = {MEM_LH, WB_MEMH};
                    F3_W:    {mem, wb} = {MEM_LW, WB_MEMW};
                    F3_BU:   {mem, wb} = {MEM_LBU, WB_MEMBU};
                    default: {mem, wb} = {MEM_LHU, WB_MEMHU};
                endcase
            OPC_STORE: begin
                s2 = OP2_IMS;
                wen = 1'b0;
                wb = WB_X;
                mem = (f3 == F3_B) ? MEM_SB : (f3 == F3_H) ? MEM_SH : MEM_SW;
            end
            OPC_BRANCH: begin
                s2 = OP2_RS2;
                wen = 1'b0;
                wb = WB_X;
                case (f3)
                    F3_BEQ:  alu = BR_BEQ;
                    F3_BNE:  alu = BR_BNE;
                    F3_BLT:  alu = BR_BLT;
                    F3_BGE:  alu = BR_BGE;
                    F3_BLTU: alu = BR_BLTU;
                    default: alu = BR_BGEU;
                endcase
            end
            OPC_JAL: begin
                {s1, s2, wb} = {OP1_PC, OP2_IMJ, WB_PC};
                jmp = 1'b1;
            end
            OPC_JALR: begin
                {alu, wb} = {ALU_JALR, WB_PC};
                jmp = 1'b1;
            end
            OPC_LUI:   {s1, s2} = {OP1_X, OP2_IMU};
            OPC_AUIPC: {s1, s2} = {OP1_PC, OP2_IMU};
            default: begin
                {s1, s2, wb} = {OP1_X, OP2_X, WB_X};
                wen = 1'b0;
            end
        endcase
    endtask

    // one model cycle once the inputs of the cycle are driven
    task automatic model_cycle();
        word_t     cur_pc;
        word_t     cur_inst;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      exp_hazard;
        logic      stall_now;
        op1_sel_t  s1;
        op2_sel_t  s2;
        if (branch_flush) begin
            cur_pc = PC_NOP;
            cur_inst = INST_NOP;
        end else if (m_held) begin
            cur_pc = m_held_pc;
            cur_inst = m_held_inst;
        end else begin
            cur_pc = in_valid ? in_pc : PC_NOP;
            cur_inst = in_valid ? in_inst : INST_NOP;
        end
        rs1 = cur_inst[19:15];
        rs2 = cur_inst[24:20];
        exp_hazard = !branch_flush && (write_pending(rs1) || write_pending(rs2));
        check("hazard_stall", hazard_stall, exp_hazard);
        stall_now = mem_stall || exp_hazard;
        if (stall_now) begin
            load_bubble();
        end else begin
            decode_model(cur_inst, exp_alu, s1, s2, exp_mem, exp_rf_wen, exp_wb_sel, exp_jmp);
            exp_pc = cur_pc;
            exp_inst = cur_inst;
            exp_imm_i = $signed(cur_inst) >>> 20;
            exp_imm_s = {exp_imm_i[31:5], cur_inst[11:7]};
            exp_imm_b = {{20{cur_inst[31]}}, cur_inst[7], cur_inst[30:25], cur_inst[11:8], 1'b0};
            exp_imm_j = {{12{cur_inst[31]}}, cur_inst[19:12], cur_inst[20], cur_inst[30:21], 1'b0};
            exp_imm_u = {cur_inst[31:12], 12'h000};
            exp_op1 = (s1 == OP1_RS1) ? m_regs[rs1] : (s1 == OP1_PC) ? cur_pc : '0;
            case (s2)
                OP2_RS2: exp_op2 = m_regs[rs2];
                OP2_IMI: exp_op2 = exp_imm_i;
                OP2_IMS: exp_op2 = exp_imm_s;
                OP2_IMJ: exp_op2 = exp_imm_j;
                OP2_IMU: exp_op2 = exp_imm_u;
                default: exp_op2 = '0;
            endcase
            exp_rs2 = m_regs[rs2];
            exp_wb_addr = cur_inst[11:7];
        end
        if (stall_now) begin
            m_held_pc = cur_pc;
            m_held_inst = cur_inst;
        end
        m_held = stall_now && !branch_flush;
    endtask

    task automatic check_outputs();
        check("out_pc", out_pc, exp_pc);
        check("out_inst", out_inst, exp_inst);
        check("out_imm_i", out_imm_i, exp_imm_i);
        check("out_imm_s", out_imm_s, exp_imm_s);
        check("out_imm_b", out_imm_b, exp_imm_b);
        check("out_imm_j", out_imm_j, exp_imm_j);
        check("out_imm_u", out_imm_u, exp_imm_u);
        check("out_op1_data", out_op1_data, exp_op1);
        check("out_op2_data", out_op2_data, exp_op2);
        check("out_rs2_data", out_rs2_data, exp_rs2);
        check("out_wb_addr", out_wb_addr, exp_wb_addr);
        check("out_alu_fun", out_alu_fun, exp_alu);
        check("out_mem_fun", out_mem_fun, exp_mem);
        check("out_rf_wen", out_rf_wen, exp_rf_wen);
        check("out_wb_sel", out_wb_sel, exp_wb_sel);
        check("out_jmp_flg", out_jmp_flg, exp_jmp);
    endtask

    // random kept instruction with legal funct fields
    task automatic make_inst(output word_t ins);
        int         kind;
        logic       alt;
        logic [2:0] f3;
        ins = $random(seed);
        kind = {$random(seed)} % 9;
        alt = ins[31];
        f3 = ins[14:12];
        case (kind)
            0: begin
                ins[6:0] = OPC_OP;
                ins[31:25] = (alt && (f3 == F3_ADD || f3 == F3_SR)) ? F7_ALT : F7_BASE;
            end
            1: begin
                ins[6:0] = OPC_OP_IMM;
                if (f3 == F3_SLL)
                    ins[31:25] = F7_BASE;
                else if (f3 == F3_SR)
                    ins[31:25] = alt ? F7_ALT : F7_BASE;
            end
            2: begin
                ins[6:0] = OPC_LOAD;
                f3 = f3 % 3'd5;
                if (f3 > F3_W)
                    f3 = f3 + 3'd1;  // skip the unused size 3
            end
            3: begin
                ins[6:0] = OPC_STORE;
                f3 = f3 % 3'd3;
            end
            4: begin
                ins[6:0] = OPC_BRANCH;
                f3 = f3 % 3'd6;
                if (f3 > F3_BNE)
                    f3 = f3 + 3'd2;
            end
            5: ins[6:0] = OPC_JAL;
            6: begin
                ins[6:0] = OPC_JALR;
                f3 = F3_JALR;
            end
            7: ins[6:0] = OPC_LUI;
            default: ins[6:0] = OPC_AUIPC;
        endcase
        ins[14:12] = f3;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        r = $random(seed);
        in_valid = (r[2:0] != 3'd0);
        branch_flush = (r[7:4] == 4'd0);
        mem_stall = (r[11:9] == 3'd0);
        {exe_rf_wen, mem_rf_wen, wb_rf_wen} = r[14:12];
        exe_wb_addr = r[19:15];
        mem_wb_addr = r[24:20];
        wb_wb_addr = r[29:25];
        r = $random(seed);
        rf_we = r[0];
        rf_waddr = r[5:1];
        rf_wdata = $random(seed);
        in_pc = {r[31:8], 4'h0, r[7:6], 2'b00};
        make_inst(in_inst);
    endtask

    initial begin
        seed = 32'h5420_bf7d;
        reset = 1'b1;
        {in_valid, mem_stall, branch_flush, rf_we} = '0;
        {exe_rf_wen, mem_rf_wen, wb_rf_wen} = '0;
        {exe_wb_addr, mem_wb_addr, wb_wb_addr, rf_waddr} = '0;
        in_pc = '0;
        in_inst = INST_NOP;
        rf_wdata = '0;
        for (int i = 0; i < REG_COUNT; i++)
            m_regs[i] = '0;
        m_held = 1'b0;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        load_bubble();
        check_outputs();  // bubble out of reset
        #1 model_cycle();  // idle inputs give the NOP decode
        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            @(posedge clk);
            #1;
            check_outputs();
            if (rf_we && rf_waddr != 5'd0)
                m_regs[rf_waddr] = rf_wdata;
            drive_random();
            #1;
            model_cycle();
        end
        @(posedge clk);
        #1;
        check_outputs();
        errors += i_decode_stage.i_decode_stage_assert.fail_count;
        $display("checks %0d, errors %0d (assertion failures %0d)", checks, errors,
                 i_decode_stage.i_decode_stage_assert.fail_count);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
verilog/decode_pkg.sv
verilog/inst_hold.sv
verilog/control_decoder.sv
verilog/operand_select.sv
verilog/reg_file.sv
verilog/hazard_detect.sv
verilog/decode_output_reg.sv
verilog/decode_stage.sv
verification/decode_stage_assert.sv
verification/decode_stage_tb.sv
